/* decodeStage_config.svh */
// Width settings shared by the decode stage and its packages
// The instruction layout in quplsInstrPkg assumes a 40-bit word and 6-bit register numbers
// Prefix payloads are fixed at 32 bits and are not set here

`ifndef DECODESTAGE_CONFIG_SVH
`define DECODESTAGE_CONFIG_SVH

// ====================
// Instruction word
// ====================

// Fetched instruction width in bits
`define INSTR_WIDTH 40

// Width of a register number field
`define REG_WIDTH 6

// ====================
// Decode results
// ====================

// Width of the decoded, sign-extended immediate
`define IMM_WIDTH 64

// Width of the decode and prefix counters
// Both counters stop at all ones instead of wrapping
`define COUNT_WIDTH 16

`endif

/* quplsInstrPkg.sv */
// Opcodes and field layouts of the 40-bit instruction word
// Only opcodes handled by the decode stage are listed; other values decode as unknown
// The short immediate form has no struct of its own and is read from the raw view

`include "decodeStage_config.svh"

package quplsInstrPkg;

	// ====================
	// Opcodes
	// ====================

	// Major opcode in bits 6 to 0
	typedef enum logic [6:0] {
		OP_SYS    = 7'd0,
		OP_R2     = 7'd2,
		OP_ADDI   = 7'd4,
		OP_SUBFI  = 7'd5,
		OP_CMPI   = 7'd6,
		OP_ANDI   = 7'd8,
		OP_ORI    = 7'd9,
		OP_EORI   = 7'd10,
		OP_SLTI   = 7'd11,
		OP_ADDSI  = 7'd12,
		OP_ANDSI  = 7'd13,
		OP_ORSI   = 7'd14,
		OP_EORSI  = 7'd15,
		OP_SHIFT  = 7'd16,
		OP_FLT3   = 7'd17,
		OP_MOV    = 7'd18,
		OP_CSR    = 7'd19,
		OP_BSR    = 7'd32,
		OP_FENCE  = 7'd120,
		OP_PFXA32 = 7'd124,
		OP_NOP    = 7'd127
	} opcode_t;

	// ====================
	// Field layouts
	// ====================

	// Register form with three sources and a function code
	// Shift and three-operand float reuse this layout but carry precision at bits 35 to 34
	typedef struct packed {
		logic [6:0] func;
		logic [1:0] prec;
		logic [`REG_WIDTH-1:0] rc;
		logic [`REG_WIDTH-1:0] rb;
		logic [`REG_WIDTH-1:0] ra;
		logic [`REG_WIDTH-1:0] rt;
		opcode_t opcode;
	} r2Fmt_t;

	// Long immediate form with a 19-bit constant in the top bits
	typedef struct packed {
		logic [18:0] imm;
		logic [1:0] prec;
		logic [`REG_WIDTH-1:0] ra;
		logic [`REG_WIDTH-1:0] rt;
		opcode_t opcode;
	} riFmt_t;

	// One fetched word seen through either layout or as plain bits
	// All members are exactly INSTR_WIDTH bits wide
	typedef union packed {
		r2Fmt_t r2;
		riFmt_t ri;
		logic [`INSTR_WIDTH-1:0] raw;
	} instrWord_t;

endpackage

/* quplsDecodePkg.sv */
// Enumerations produced and used by the decoders
// Precision codes follow the two-bit field in the instruction word

package quplsDecodePkg;

	// ====================
	// Operand precision
	// ====================

	// Operand size selected by the precision field
	// Instructions without such a field run at octa precision
	typedef enum logic [1:0] {
		PREC_BYTE  = 2'd0,
		PREC_WYDE  = 2'd1,
		PREC_TETRA = 2'd2,
		PREC_OCTA  = 2'd3
	} prec_t;

	// ====================
	// Immediate source
	// ====================

	// Where the immediate constant of an instruction comes from
	// IMM_LONG is the 19-bit field at bits 39 to 21
	// IMM_SHORT is the 22-bit field at bits 39 to 18
	typedef enum logic [1:0] {
		IMM_NONE  = 2'd0,
		IMM_LONG  = 2'd1,
		IMM_SHORT = 2'd2
	} immFmt_t;

	// Prefix payload width that is spliced above either field
	// The prefix sits at instruction bits 39 to 8
	localparam int PrefixBits = 32;

	// Field widths of the two immediate forms
	localparam int LongBits = 19;
	localparam int ShortBits = 22;

endpackage

/* decodePrec.sv */
// Operand precision decoder with a registered result
// Unknown opcodes and prefixes decode as octa; the output holds until the next load

`timescale 1ns/1ps

module decodePrec (
	input  logic clk,
	input  logic rstN,
	input  logic load,
	input  quplsInstrPkg::instrWord_t instr,
	output quplsDecodePkg::prec_t prec
);

	// Picks the precision field by the major opcode
	// Each instruction class keeps its precision bits in a different place
	function automatic quplsDecodePkg::prec_t fnPrec(input quplsInstrPkg::instrWord_t ir);
		quplsDecodePkg::prec_t p;
		case (ir.r2.opcode)
			// Register form keeps precision right above Rc
			quplsInstrPkg::OP_R2:
				p = quplsDecodePkg::prec_t'(ir.r2.prec);
			// Long immediate forms have it between Ra and the constant
			quplsInstrPkg::OP_ADDI,
			quplsInstrPkg::OP_SUBFI,
			quplsInstrPkg::OP_CMPI,
			quplsInstrPkg::OP_ANDI,
			quplsInstrPkg::OP_ORI,
			quplsInstrPkg::OP_EORI,
			quplsInstrPkg::OP_SLTI:
				p = quplsDecodePkg::prec_t'(ir.ri.prec);
			// Short immediate forms drop Ra, so the field moves down
			quplsInstrPkg::OP_ADDSI,
			quplsInstrPkg::OP_ANDSI,
			quplsInstrPkg::OP_ORSI,
			quplsInstrPkg::OP_EORSI:
				p = quplsDecodePkg::prec_t'(ir.raw[17:16]);
			// Shift and float forms use part of the function field
			quplsInstrPkg::OP_SHIFT,
			quplsInstrPkg::OP_FLT3:
				p = quplsDecodePkg::prec_t'(ir.raw[35:34]);
			// System, move, CSR, NOP, fence and branch have no precision field
			default:
				p = quplsDecodePkg::PREC_OCTA;
		endcase
		return p;
	endfunction

	// The precision register loads only on an issued instruction
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			prec <= quplsDecodePkg::PREC_BYTE;
		end
		else if (load)
		begin
			prec <= fnPrec(instr);
		end
	end

endmodule

/* decodeOperands.sv */
// Register field and immediate decoder with registered results
// A pending prefix is spliced above the immediate field of the issuing instruction
// Instructions without an immediate ignore the prefix and return zero

`timescale 1ns/1ps

`include "decodeStage_config.svh"

module decodeOperands (
	input  logic clk,
	input  logic rstN,
	input  logic load,
	input  quplsInstrPkg::instrWord_t instr,
	input  logic prefixValid,
	input  logic [31:0] prefixData,
	output logic [`REG_WIDTH-1:0] rt,
	output logic [`REG_WIDTH-1:0] ra,
	output logic [`REG_WIDTH-1:0] rb,
	output logic [`IMM_WIDTH-1:0] imm,
	output logic hasImm
);

	localparam int LongBits = quplsDecodePkg::LongBits;
	localparam int ShortBits = quplsDecodePkg::ShortBits;
	localparam int PfxBits = quplsDecodePkg::PrefixBits;

	// Maps an opcode to the immediate field it carries
	// Branches are treated as having no immediate here
	function automatic quplsDecodePkg::immFmt_t fnImmFmt(input quplsInstrPkg::opcode_t op);
		quplsDecodePkg::immFmt_t f;
		case (op)
			quplsInstrPkg::OP_ADDI,
			quplsInstrPkg::OP_SUBFI,
			quplsInstrPkg::OP_CMPI,
			quplsInstrPkg::OP_ANDI,
			quplsInstrPkg::OP_ORI,
			quplsInstrPkg::OP_EORI,
			quplsInstrPkg::OP_SLTI:
				f = quplsDecodePkg::IMM_LONG;
			quplsInstrPkg::OP_ADDSI,
			quplsInstrPkg::OP_ANDSI,
			quplsInstrPkg::OP_ORSI,
			quplsInstrPkg::OP_EORSI:
				f = quplsDecodePkg::IMM_SHORT;
			default:
				f = quplsDecodePkg::IMM_NONE;
		endcase
		return f;
	endfunction

	quplsDecodePkg::immFmt_t fmt;
	logic [LongBits-1:0] longField;
	logic [ShortBits-1:0] shortField;
	logic [`IMM_WIDTH-1:0] nextImm;
	logic [`REG_WIDTH-1:0] nextRa;
	logic [`REG_WIDTH-1:0] nextRb;

	always_comb
	begin
		fmt = fnImmFmt(instr.r2.opcode);
		longField = instr.ri.imm;
		shortField = instr.raw[39:18];
		// The prefix becomes the upper part and its top bit is the sign
		case (fmt)
			quplsDecodePkg::IMM_LONG:
				nextImm = prefixValid
					? {{(`IMM_WIDTH-PfxBits-LongBits){prefixData[PfxBits-1]}}, prefixData, longField}
					: {{(`IMM_WIDTH-LongBits){longField[LongBits-1]}}, longField};
			quplsDecodePkg::IMM_SHORT:
				nextImm = prefixValid
					? {{(`IMM_WIDTH-PfxBits-ShortBits){prefixData[PfxBits-1]}}, prefixData, shortField}
					: {{(`IMM_WIDTH-ShortBits){shortField[ShortBits-1]}}, shortField};
			default:
				nextImm = '0;
		endcase
		// Short forms reuse the Ra bits for immediate and precision
		if (fmt == quplsDecodePkg::IMM_SHORT || instr.r2.opcode == quplsInstrPkg::OP_NOP)
			nextRa = '0;
		else
			nextRa = instr.ri.ra;
		// Only the register form has a second source register
		nextRb = (instr.r2.opcode == quplsInstrPkg::OP_R2) ? instr.r2.rb : '0;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			rt <= '0;
			ra <= '0;
			rb <= '0;
			imm <= '0;
			hasImm <= 1'b0;
		end
		else if (load)
		begin
			rt <= instr.r2.rt;
			ra <= nextRa;
			rb <= nextRb;
			imm <= nextImm;
			hasImm <= (fmt != quplsDecodePkg::IMM_NONE);
		end
	end

endmodule

/* decodeSequencer.sv */
// Classifies each instruction strobe as prefix or issue and holds a pending prefix
// issue and prefixTake are combinational from the strobe; decodeValid lags issue by one cycle
// A later prefix overwrites an earlier one that has not yet been used

`timescale 1ns/1ps

module decodeSequencer (
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	input  quplsInstrPkg::opcode_t opcode,
	input  logic [31:0] prefixPayload,
	output logic issue,
	output logic prefixTake,
	output logic prefixValid,
	output logic [31:0] prefixData,
	output logic decodeValid
);

	// PREFIXED means prefixData holds a prefix for the next issue
	typedef enum logic {
		IDLE,
		PREFIXED
	} seqState_t;

	seqState_t state;
	seqState_t nextState;
	logic isPrefix;

	// ====================
	// Strobe classification
	// ====================

	assign isPrefix = (opcode == quplsInstrPkg::OP_PFXA32);
	assign issue = instrValid && !isPrefix;
	assign prefixTake = instrValid && isPrefix;
	assign prefixValid = (state == PREFIXED);

	// A prefix arms the machine and any issue consumes it
	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
				if (prefixTake)
					nextState = PREFIXED;
			PREFIXED:
				if (issue)
					nextState = IDLE;
			default:
				nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			decodeValid <= 1'b0;
		end
		else
		begin
			state <= nextState;
			decodeValid <= issue;
		end
	end

	// The payload is only read while the state is PREFIXED
	always_ff @(posedge clk)
	begin
		if (prefixTake)
			prefixData <= prefixPayload;
	end

endmodule

/* decodeCounter.sv */
// Saturating counters of issued instructions and accepted prefixes
// Counts appear one cycle after the strobe and stay at all ones once full

`timescale 1ns/1ps

`include "decodeStage_config.svh"

module decodeCounter (
	input  logic clk,
	input  logic rstN,
	input  logic issue,
	input  logic prefixTake,
	output logic [`COUNT_WIDTH-1:0] decodeCount,
	output logic [`COUNT_WIDTH-1:0] prefixCount
);

	// Adds one unless the count is already at its ceiling
	function automatic logic [`COUNT_WIDTH-1:0] fnSatInc(input logic [`COUNT_WIDTH-1:0] c);
		logic [`COUNT_WIDTH-1:0] r;
		r = (&c) ? c : c + 1'b1;
		return r;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			decodeCount <= '0;
			prefixCount <= '0;
		end
		else
		begin
			// The strobes are exclusive but each counter is handled on its own
			if (issue)
				decodeCount <= fnSatInc(decodeCount);
			if (prefixTake)
				prefixCount <= fnSatInc(prefixCount);
		end
	end

endmodule

/* decodeStage.sv */
// Decode stage top level for 40-bit instructions, one instruction per strobe
// No back-pressure; results appear one cycle after an issue with a one-cycle decodeValid
// Prefixes produce no result and extend the immediate of the next issued instruction

`timescale 1ns/1ps

`include "decodeStage_config.svh"

module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  logic instrValid,
	input  logic [`INSTR_WIDTH-1:0] instr,
	output logic decodeValid,
	output quplsDecodePkg::prec_t prec,
	output logic [`REG_WIDTH-1:0] rt,
	output logic [`REG_WIDTH-1:0] ra,
	output logic [`REG_WIDTH-1:0] rb,
	output logic [`IMM_WIDTH-1:0] imm,
	output logic hasImm,
	output logic [`COUNT_WIDTH-1:0] decodeCount,
	output logic [`COUNT_WIDTH-1:0] prefixCount
);

	logic issue;
	logic prefixTake;
	logic prefixValid;
	logic [31:0] prefixData;

	// Strobe classification and prefix holding
	decodeSequencer uSeq (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.opcode(quplsInstrPkg::opcode_t'(instr[6:0])),
		.prefixPayload(instr[39:8]),
		.issue(issue),
		.prefixTake(prefixTake),
		.prefixValid(prefixValid),
		.prefixData(prefixData),
		.decodeValid(decodeValid)
	);

	decodeCounter uCount (
		.clk(clk),
		.rstN(rstN),
		.issue(issue),
		.prefixTake(prefixTake),
		.decodeCount(decodeCount),
		.prefixCount(prefixCount)
	);

	// Both decoders see the raw word and load together on issue
	decodePrec uPrec (
		.clk(clk),
		.rstN(rstN),
		.load(issue),
		.instr(instr),
		.prec(prec)
	);

	decodeOperands uOps (
		.clk(clk),
		.rstN(rstN),
		.load(issue),
		.instr(instr),
		.prefixValid(prefixValid),
		.prefixData(prefixData),
		.rt(rt),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.hasImm(hasImm)
	);

endmodule

/* decodeStage_props.sv */
// Bound checks on decodeValid timing and on the counter state during reset
// Strobes are classified from the top-level instruction port
// Timing checks are switched off while rstN is low

`timescale 1ns/1ps

`include "decodeStage_config.svh"

module decodeStageProps (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [`INSTR_WIDTH-1:0] instr,
	input logic decodeValid,
	input logic [`COUNT_WIDTH-1:0] decodeCount,
	input logic [`COUNT_WIDTH-1:0] prefixCount
);

	logic isPrefix;
	logic isIssue;

	// A strobe with the prefix opcode carries no instruction to decode
	assign isPrefix = (instr[6:0] == quplsInstrPkg::OP_PFXA32);
	assign isIssue = instrValid && !isPrefix;

	// ====================
	// Result timing
	// ====================

	// An issued instruction gives a result exactly one edge later
	issueToValid: assert property (@(posedge clk) disable iff (!rstN) isIssue |=> decodeValid)
		else $error("decodeValid did not follow an issue by one cycle");

	// A prefix on its own never produces a result
	prefixNoValid: assert property (@(posedge clk) disable iff (!rstN)
		(instrValid && isPrefix) |=> !decodeValid)
		else $error("decodeValid was raised after a prefix");

	// ====================
	// Reset state
	// ====================

	// Counters read zero on the edge after any reset edge
	countsReset: assert property (@(posedge clk)
		!rstN |=> (decodeCount == '0 && prefixCount == '0))
		else $error("Counters are not zero during reset");

endmodule

bind decodeStage decodeStageProps uProps (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.instr(instr),
	.decodeValid(decodeValid),
	.decodeCount(decodeCount),
	.prefixCount(prefixCount)
);

/* tbClock.sv */
// Clock and reset source for the testbench
// 8 ns clock period; rstN stays low for the first 3 rising edges

`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// Reset is released 1 ns after the third edge, away from any clock edge
	initial
	begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

endmodule

/* decodeStageTb.sv */
// Self-checking testbench for the decode stage with directed and random instruction streams
// Expected values come from a reference model of the decode rules and of the pending prefix

`timescale 1ns/1ps

`include "decodeStage_config.svh"

module decodeStageTb;

	// Cycles a wait may take before it counts as a hang
	localparam int Timeout = 50;

	typedef struct packed {
		logic [1:0] prec;
		logic [`REG_WIDTH-1:0] rt;
		logic [`REG_WIDTH-1:0] ra;
		logic [`REG_WIDTH-1:0] rb;
		logic [`IMM_WIDTH-1:0] imm;
		logic hasImm;
	} expect_t;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [`INSTR_WIDTH-1:0] instr;
	logic decodeValid;
	quplsDecodePkg::prec_t prec;
	logic [`REG_WIDTH-1:0] rt;
	logic [`REG_WIDTH-1:0] ra;
	logic [`REG_WIDTH-1:0] rb;
	logic [`IMM_WIDTH-1:0] imm;
	logic hasImm;
	logic [`COUNT_WIDTH-1:0] decodeCount;
	logic [`COUNT_WIDTH-1:0] prefixCount;

	// Model of the pending prefix, the tallies and the results still in flight
	logic pfxValid = 1'b0;
	logic [31:0] pfxData = '0;
	int issueTally = 0;
	int prefixTally = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	logic stimDone = 1'b0;
	logic compareDone = 1'b0;
	integer seed;
	expect_t expQ[$];
	string nameQ[$];

	// Known opcodes of every class plus three that the decoders do not know
	logic [6:0] opTable [0:22] = '{
		quplsInstrPkg::OP_SYS, quplsInstrPkg::OP_R2, quplsInstrPkg::OP_ADDI,
		quplsInstrPkg::OP_SUBFI, quplsInstrPkg::OP_CMPI, quplsInstrPkg::OP_ANDI,
		quplsInstrPkg::OP_ORI, quplsInstrPkg::OP_EORI, quplsInstrPkg::OP_SLTI,
		quplsInstrPkg::OP_ADDSI, quplsInstrPkg::OP_ANDSI, quplsInstrPkg::OP_ORSI,
		quplsInstrPkg::OP_EORSI, quplsInstrPkg::OP_SHIFT, quplsInstrPkg::OP_FLT3,
		quplsInstrPkg::OP_MOV, quplsInstrPkg::OP_CSR, quplsInstrPkg::OP_NOP,
		quplsInstrPkg::OP_FENCE, quplsInstrPkg::OP_BSR, 7'd1, 7'd64, 7'd99
	};

	tbClock uClock (
		.clk(clk),
		.rstN(rstN)
	);

	decodeStage dut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.decodeValid(decodeValid),
		.prec(prec),
		.rt(rt),
		.ra(ra),
		.rb(rb),
		.imm(imm),
		.hasImm(hasImm),
		.decodeCount(decodeCount),
		.prefixCount(prefixCount)
	);

	// ====================
	// Reference model
	// ====================

	// Expected decode of one issued word, given the prefix that is pending at that time
	function automatic expect_t refDecode(input logic [39:0] w, input logic pv,
		input logic [31:0] pd);
		expect_t e;
		logic isLong;
		logic isShort;
		logic [63:0] v;
		int width;
		isLong = w[6:0] inside {quplsInstrPkg::OP_ADDI, quplsInstrPkg::OP_SUBFI,
			quplsInstrPkg::OP_CMPI, quplsInstrPkg::OP_ANDI, quplsInstrPkg::OP_ORI,
			quplsInstrPkg::OP_EORI, quplsInstrPkg::OP_SLTI};
		isShort = w[6:0] inside {quplsInstrPkg::OP_ADDSI, quplsInstrPkg::OP_ANDSI,
			quplsInstrPkg::OP_ORSI, quplsInstrPkg::OP_EORSI};
		e = '0;
		// Precision location depends on the instruction class, octa when there is none
		e.prec = 2'd3;
		if (w[6:0] == quplsInstrPkg::OP_R2)
			e.prec = w[32:31];
		else if (isLong)
			e.prec = w[20:19];
		else if (isShort)
			e.prec = w[17:16];
		else if (w[6:0] == quplsInstrPkg::OP_SHIFT || w[6:0] == quplsInstrPkg::OP_FLT3)
			e.prec = w[35:34];
		e.rt = w[12:7];
		if (!isShort && w[6:0] != quplsInstrPkg::OP_NOP)
			e.ra = w[18:13];
		if (w[6:0] == quplsInstrPkg::OP_R2)
			e.rb = w[24:19];
		// Build the constant bottom up, then extend its top bit over the rest
		v = '0;
		width = 0;
		if (isLong)
		begin
			v = 64'(w[39:21]);
			width = 19;
		end
		else if (isShort)
		begin
			v = 64'(w[39:18]);
			width = 22;
		end
		if (width != 0)
		begin
			if (pv)
			begin
				v = v | (64'(pd) << width);
				width = width + 32;
			end
			if (v[width-1])
				v = v | ({64{1'b1}} << width);
			e.hasImm = 1'b1;
		end
		e.imm = v;
		return e;
	endfunction

	// ====================
	// Stimulus helpers
	// ====================

	// Drives one strobe and updates the prefix model the way the DUT should
	task automatic sendInstr(input logic [39:0] w, input string name);
		expect_t e;
		@(posedge clk);
		#1;
		instrValid = 1'b1;
		instr = w;
		if (w[6:0] == quplsInstrPkg::OP_PFXA32)
		begin
			pfxValid = 1'b1;
			pfxData = w[39:8];
			prefixTally++;
		end
		else
		begin
			e = refDecode(w, pfxValid, pfxData);
			expQ.push_back(e);
			nameQ.push_back(name);
			pfxValid = 1'b0;
			issueTally++;
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			instrValid = 1'b0;
		end
	endtask

	// Random word with the given opcode in the low bits
	task automatic randWord(input logic [6:0] op, output logic [39:0] w);
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		w = {hi, lo[7:0]};
		w[6:0] = op;
	endtask

	task automatic checkField(input string name, input string field,
		input logic [63:0] expv, input logic [63:0] actv);
		if (expv !== actv)
		begin
			$display("FAILED %s %s expected %h actual %h", name, field, expv, actv);
			valueErrors++;
		end
	endtask

	// ====================
	// Comparing process
	// ====================

	// Sampled at the falling edge, halfway between register updates
	initial
	begin : compareProc
		expect_t e;
		string name;
		int idle;
		idle = 0;
		while (!(stimDone && expQ.size() == 0))
		begin
			@(negedge clk);
			if (rstN === 1'b1 && decodeValid === 1'b1)
			begin
				idle = 0;
				if (expQ.size() == 0)
				begin
					$display("decodeValid was raised with no instruction issued");
					otherErrors++;
				end
				else
				begin
					e = expQ.pop_front();
					name = nameQ.pop_front();
					checkField(name, "prec", 64'(e.prec), 64'(prec));
					checkField(name, "rt", 64'(e.rt), 64'(rt));
					checkField(name, "ra", 64'(e.ra), 64'(ra));
					checkField(name, "rb", 64'(e.rb), 64'(rb));
					checkField(name, "imm", e.imm, imm);
					checkField(name, "hasImm", 64'(e.hasImm), 64'(hasImm));
				end
			end
			else if (expQ.size() != 0)
			begin
				idle++;
				// A lost result would stall every later comparison, so drop them all
				if (idle > Timeout)
				begin
					$display("Timed out waiting for decodeValid of %s", nameQ[0]);
					otherErrors++;
					expQ.delete();
					nameQ.delete();
					idle = 0;
				end
			end
		end
		compareDone = 1'b1;
	end

	// ====================
	// Stimulus
	// ====================

	initial
	begin : stimulus
		int n;
		int k;
		int idx;
		logic [31:0] r;
		logic [6:0] op;
		logic [39:0] w;
		seed = 61;
		instrValid = 1'b0;
		instr = '0;
		n = 0;
		while (rstN !== 1'b1 && n < Timeout)
		begin
			@(posedge clk);
			n++;
		end
		if (rstN !== 1'b1)
		begin
			$display("Reset was never released");
			otherErrors++;
		end
		// State right after reset, before the first strobe
		@(negedge clk);
		checkField("reset", "decodeValid", 64'(0), 64'(decodeValid));
		checkField("reset", "decodeCount", 64'(0), 64'(decodeCount));
		checkField("reset", "prefixCount", 64'(0), 64'(prefixCount));
		checkField("reset", "imm", 64'(0), imm);

		// Both signs of the long and short immediate fields
		sendInstr({19'h01234, 2'd2, 6'd5, 6'd9, quplsInstrPkg::OP_ADDI}, "longPos");
		idleCycles(1);
		sendInstr({19'h7FF00, 2'd1, 6'd7, 6'd3, quplsInstrPkg::OP_ADDI}, "longNeg");
		idleCycles(2);
		sendInstr({22'h0ABCDE, 2'd0, 3'd5, 6'd11, quplsInstrPkg::OP_ADDSI}, "shortPos");
		sendInstr({22'h3F0001, 2'd3, 3'd2, 6'd12, quplsInstrPkg::OP_EORSI}, "shortNeg");
		idleCycles(1);

		// The prefix lands on the next immediate only
		sendInstr({32'h8000_1234, 1'b0, quplsInstrPkg::OP_PFXA32}, "pfxA");
		sendInstr({19'h00042, 2'd3, 6'd1, 6'd2, quplsInstrPkg::OP_ORI}, "pfxLong");
		sendInstr({19'h00042, 2'd3, 6'd1, 6'd2, quplsInstrPkg::OP_ORI}, "afterPfx");
		idleCycles(1);

		// Back-to-back prefixes keep the last one
		sendInstr({32'h1111_1111, 1'b0, quplsInstrPkg::OP_PFXA32}, "pfxFirst");
		sendInstr({32'h0000_00AB, 1'b0, quplsInstrPkg::OP_PFXA32}, "pfxSecond");
		idleCycles(2);
		sendInstr({22'h200000, 2'd1, 3'd0, 6'd4, quplsInstrPkg::OP_ANDSI}, "pfxShort");

		// A form without an immediate still consumes the prefix
		sendInstr({32'hFFFF_0000, 1'b0, quplsInstrPkg::OP_PFXA32}, "pfxB");
		sendInstr({33'h1_2345_6789, quplsInstrPkg::OP_NOP}, "pfxNop");
		sendInstr({19'h40000, 2'd0, 6'd8, 6'd6, quplsInstrPkg::OP_SLTI}, "nopConsumed");
		idleCycles(1);

		// Random stream with gaps of zero to two cycles
		for (k = 0; k < 300; k++)
		begin
			r = $random(seed);
			idx = $unsigned(r[15:8]) % 23;
			op = r[3] ? opTable[idx] : r[30:24];
			if (r[2:0] == 3'd0)
				op = quplsInstrPkg::OP_PFXA32;
			randWord(op, w);
			sendInstr(w, "random");
			if (r[21:20] != 2'd3 && r[21:20] != 2'd0)
				idleCycles(int'(r[21:20]));
		end
		idleCycles(2);
		stimDone = 1'b1;

		n = 0;
		while (!compareDone && n < 4 * Timeout)
		begin
			@(posedge clk);
			n++;
		end
		if (!compareDone)
		begin
			$display("The comparing process did not finish in time");
			otherErrors++;
		end
		checkField("counts", "decodeCount", 64'(issueTally), 64'(decodeCount));
		checkField("counts", "prefixCount", 64'(prefixTally), 64'(prefixCount));

		$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* decodeStage.f */
+incdir+.
quplsInstrPkg.sv
quplsDecodePkg.sv
decodePrec.sv
decodeOperands.sv
decodeSequencer.sv
decodeCounter.sv
decodeStage.sv
decodeStage_props.sv
tbClock.sv
decodeStageTb.sv

/* run.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module decodeStageTb -f decodeStage.f -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
